// File: adder_pkg.sv
/*
 * adder issue path shared definitions.
 * data and tag widths, buffer depth, one-hot operation bit positions
 * and the second operand union of a dispatched instruction.
 */
package adder_pkg;

	localparam int XLEN = 64;
	localparam int PHY_REGS = 64;
	localparam int PHY_W = 6;
	localparam int ISSUE_DEPTH = 8;
	localparam int IDX_W = 3;
	localparam int OP_W = 8;

	// one-hot operation bit positions.
	localparam int OP_LUI = 7;
	localparam int OP_AUIPC = 6;
	localparam int OP_ADDI = 5;
	localparam int OP_ADDIW = 4;
	localparam int OP_ADD = 3;
	localparam int OP_ADDW = 2;
	localparam int OP_SUB = 1;
	localparam int OP_SUBW = 0;

	// immediate forms read imm, register forms read the rs2 tag.
	typedef union packed {
		logic [XLEN-1:0] imm;
		struct packed {
			logic [XLEN-PHY_W-1:0] pad;
			logic [PHY_W-1:0] rs2;
		} reg_form;
	} operand2_u;

endpackage

// File: adder_ifs.sv
/*
 * adder issue path interfaces.
 * issue buffer entries towards issue, register file reads,
 * and the four-phase writeback request link.
 */
`timescale 1ns/100ps

interface issue_buf_if
	import adder_pkg::*;
();
	logic [ISSUE_DEPTH-1:0] malloc;
	logic [ISSUE_DEPTH-1:0][OP_W-1:0] op;
	logic [ISSUE_DEPTH-1:0][XLEN-1:0] pc;
	logic [ISSUE_DEPTH-1:0][PHY_W-1:0] rd;
	logic [ISSUE_DEPTH-1:0][PHY_W-1:0] rs1;
	operand2_u [ISSUE_DEPTH-1:0] opnd2;
	logic pop;
	logic [IDX_W-1:0] pop_index;

	modport src (output malloc, op, pc, rd, rs1, opnd2, input pop, pop_index);
	modport sink (input malloc, op, pc, rd, rs1, opnd2, output pop, pop_index);
endinterface

interface rf_read_if
	import adder_pkg::*;
();
	logic [PHY_REGS-1:0] ready;
	logic [PHY_W-1:0] rs1;
	logic [PHY_W-1:0] rs2;
	logic [XLEN-1:0] data1;
	logic [XLEN-1:0] data2;

	modport reader (input ready, data1, data2, output rs1, rs2);
	modport port (output ready, data1, data2, input rs1, rs2);
endinterface

interface wb_if
	import adder_pkg::*;
();
	logic req;
	logic ack;
	logic [PHY_W-1:0] rd;
	logic [XLEN-1:0] data;

	modport requester (output req, rd, data, input ack);
	modport arbiter (input req, rd, data, output ack);
endinterface

// File: adder_buffer.sv
/*
 * adder issue buffer.
 * accepts renamed add-class instructions by a four-phase handshake,
 * keeps them in eight entries and frees an entry when issue pops it.
 */
`timescale 1ns/100ps

module adder_buffer
	import adder_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic dispatch_req,
	input logic [OP_W-1:0] dispatch_op,
	input logic [XLEN-1:0] dispatch_pc,
	input logic [PHY_W-1:0] dispatch_rd,
	input logic [PHY_W-1:0] dispatch_rs1,
	input operand2_u dispatch_opnd2,
	output logic dispatch_ack,
	output logic alloc_clr,
	output logic [PHY_W-1:0] alloc_clr_rd,
	issue_buf_if.src issue_buf
);

	logic [ISSUE_DEPTH-1:0] malloc_q;
	logic [ISSUE_DEPTH-1:0][OP_W-1:0] op_q;
	logic [ISSUE_DEPTH-1:0][XLEN-1:0] pc_q;
	logic [ISSUE_DEPTH-1:0][PHY_W-1:0] rd_q;
	logic [ISSUE_DEPTH-1:0][PHY_W-1:0] rs1_q;
	operand2_u [ISSUE_DEPTH-1:0] opnd2_q;
	logic [IDX_W-1:0] free_idx;
	logic free_any;
	logic ack_q;
	logic take;

	// lowest free entry.
	always_comb begin
		free_idx = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (!malloc_q[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	assign free_any = ~&malloc_q;
	// new request seen while ack is low and an entry is free.
	assign take = dispatch_req & ~ack_q & free_any;

	assign dispatch_ack = ack_q;
	assign alloc_clr = take;
	assign alloc_clr_rd = dispatch_rd;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			malloc_q <= '0;
		end else begin
			if (ack_q) begin
				ack_q <= dispatch_req;
			end else begin
				ack_q <= take;
			end
			if (issue_buf.pop) begin
				malloc_q[issue_buf.pop_index] <= 1'b0;
			end
			if (take) begin
				malloc_q[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			op_q[free_idx] <= dispatch_op;
			pc_q[free_idx] <= dispatch_pc;
			rd_q[free_idx] <= dispatch_rd;
			rs1_q[free_idx] <= dispatch_rs1;
			opnd2_q[free_idx] <= dispatch_opnd2;
		end
	end

	assign issue_buf.malloc = malloc_q;
	assign issue_buf.op = op_q;
	assign issue_buf.pc = pc_q;
	assign issue_buf.rd = rd_q;
	assign issue_buf.rs1 = rs1_q;
	assign issue_buf.opnd2 = opnd2_q;

endmodule

// File: adder_issue.sv
/*
 * adder issue select.
 * checks source readiness of every buffered entry, picks the lowest
 * ready index, reads its operands and hands op1/op2 to the adder.
 */
`timescale 1ns/100ps

module adder_issue
	import adder_pkg::*;
(
	input logic execute_ready,
	output logic execute_valid,
	output logic [OP_W-1:0] execute_op,
	output logic [PHY_W-1:0] execute_rd,
	output logic [XLEN-1:0] execute_op1,
	output logic [XLEN-1:0] execute_op2,
	output logic execute_is32,
	issue_buf_if.sink issue_buf,
	rf_read_if.reader rf
);

	logic [ISSUE_DEPTH-1:0] clear;
	logic [IDX_W-1:0] sel;
	logic any_clear;
	logic [OP_W-1:0] sel_op;
	operand2_u sel_opnd2;
	logic use_imm;

	for (genvar i = 0; i < ISSUE_DEPTH; i++) begin : g_entry
		logic [OP_W-1:0] op;
		logic no_src;
		logic reg_form;
		logic rs1_rdy;
		logic rs2_rdy;

		assign op = issue_buf.op[i];
		assign no_src = op[OP_LUI] | op[OP_AUIPC];
		assign reg_form = op[OP_ADD] | op[OP_ADDW] | op[OP_SUB] | op[OP_SUBW];
		assign rs1_rdy = rf.ready[issue_buf.rs1[i]];
		// the rs2 tag only means something for register forms.
		assign rs2_rdy = rf.ready[issue_buf.opnd2[i].reg_form.rs2];

		assign clear[i] = issue_buf.malloc[i]
			& (no_src | (rs1_rdy & (~reg_form | rs2_rdy)));
	end

	// lowest index wins.
	always_comb begin
		sel = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (clear[i]) begin
				sel = IDX_W'(i);
			end
		end
	end

	assign any_clear = |clear;

	assign sel_op = issue_buf.op[sel];
	assign sel_opnd2 = issue_buf.opnd2[sel];

	assign rf.rs1 = issue_buf.rs1[sel];
	assign rf.rs2 = sel_opnd2.reg_form.rs2;

	always_comb begin
		if (sel_op[OP_LUI]) begin
			execute_op1 = '0;
		end else if (sel_op[OP_AUIPC]) begin
			execute_op1 = issue_buf.pc[sel];
		end else begin
			execute_op1 = rf.data1;
		end
	end

	assign use_imm = sel_op[OP_LUI] | sel_op[OP_AUIPC] | sel_op[OP_ADDI] | sel_op[OP_ADDIW];
	assign execute_op2 = use_imm ? sel_opnd2.imm : rf.data2;

	assign execute_is32 = sel_op[OP_ADDIW] | sel_op[OP_ADDW] | sel_op[OP_SUBW];
	assign execute_op = sel_op;
	assign execute_rd = issue_buf.rd[sel];
	assign execute_valid = any_clear;

	assign issue_buf.pop = any_clear & execute_ready;
	assign issue_buf.pop_index = sel;

endmodule

// File: phy_regfile.sv
/*
 * physical register file.
 * 64 x 64-bit registers with a ready bit each, two combinational
 * read ports and one write port fed by the writeback arbiter.
 */
`timescale 1ns/100ps

module phy_regfile
	import adder_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic alloc_clr,
	input logic [PHY_W-1:0] alloc_clr_rd,
	input logic alloc_valid,
	input logic [PHY_W-1:0] alloc_rd,
	wb_if.arbiter wr,
	rf_read_if.port rd
);

	logic [XLEN-1:0] regs_q [PHY_REGS];
	logic [PHY_REGS-1:0] ready_q;
	logic [PHY_REGS-1:0] ready_d;

	// the write is applied last so it wins over a clear of the same tag.
	always_comb begin
		ready_d = ready_q;
		if (alloc_clr) begin
			ready_d[alloc_clr_rd] = 1'b0;
		end
		if (alloc_valid) begin
			ready_d[alloc_rd] = 1'b0;
		end
		if (wr.req) begin
			ready_d[wr.rd] = 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			ready_q <= '1;
			for (int i = 0; i < PHY_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			ready_q <= ready_d;
			if (wr.req) begin
				regs_q[wr.rd] <= wr.data;
			end
		end
	end

	// a strobe is always taken in its own cycle.
	assign wr.ack = wr.req;

	assign rd.ready = ready_q;
	assign rd.data1 = regs_q[rd.rs1];
	assign rd.data2 = regs_q[rd.rs2];

endmodule

// File: adder_execute.sv
/*
 * adder execute unit.
 * one-stage add/sub with 32-bit sign extension for the w forms;
 * holds the result and its request through the four-phase write.
 */
`timescale 1ns/100ps

module adder_execute
	import adder_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic execute_valid,
	input logic [OP_W-1:0] execute_op,
	input logic [PHY_W-1:0] execute_rd,
	input logic [XLEN-1:0] execute_op1,
	input logic [XLEN-1:0] execute_op2,
	input logic execute_is32,
	output logic execute_ready,
	wb_if.requester wb
);

	logic req_q;
	logic [OP_W-1:0] op_q;
	logic [PHY_W-1:0] rd_q;
	logic [XLEN-1:0] op1_q;
	logic [XLEN-1:0] op2_q;
	logic is32_q;
	logic accept;
	logic is_sub;
	logic [XLEN-1:0] sum;

	// busy from accept until the request has dropped.
	assign execute_ready = ~req_q;
	assign accept = execute_valid & execute_ready;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			req_q <= 1'b0;
		end else if (req_q) begin
			req_q <= ~wb.ack;
		end else begin
			req_q <= accept;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			op_q <= execute_op;
			rd_q <= execute_rd;
			op1_q <= execute_op1;
			op2_q <= execute_op2;
			is32_q <= execute_is32;
		end
	end

	assign is_sub = op_q[OP_SUB] | op_q[OP_SUBW];
	assign sum = is_sub ? (op1_q - op2_q) : (op1_q + op2_q);

	assign wb.req = req_q;
	assign wb.rd = rd_q;
	assign wb.data = is32_q ? {{(XLEN-32){sum[31]}}, sum[31:0]} : sum;

endmodule

// File: wb_arbiter.sv
/*
 * writeback arbiter.
 * round-robin between the adder and the external writer for the
 * single register file write port, one write strobe per grant.
 */
`timescale 1ns/100ps

module wb_arbiter
	import adder_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	wb_if.arbiter adder_wb,
	wb_if.arbiter ext_wb,
	wb_if.requester rf_wb
);

	// bit 0 is the adder, bit 1 the external writer.
	logic [1:0] req;
	logic [1:0] grant;
	logic [1:0] ack;
	logic [1:0] sel_q;
	logic [1:0] ack_q;
	logic prio_q;
	logic strobe_q;
	logic [PHY_W-1:0] rd_q;
	logic [XLEN-1:0] data_q;

	assign req = {ext_wb.req, adder_wb.req};

	always_comb begin
		grant = 2'b00;
		if (sel_q == 2'b00) begin
			case (req)
				2'b01: grant = 2'b01;
				2'b10: grant = 2'b10;
				2'b11: grant = prio_q ? 2'b10 : 2'b01;
				default: grant = 2'b00;
			endcase
		end
	end

	// ack rises with the write and holds until the owner drops req.
	assign ack = sel_q & (ack_q | {2{rf_wb.ack}});
	assign adder_wb.ack = ack[0];
	assign ext_wb.ack = ack[1];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			sel_q <= 2'b00;
			ack_q <= 2'b00;
			prio_q <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= |grant;
			ack_q <= ack & req;
			if (|grant) begin
				sel_q <= grant;
				prio_q <= grant[0];
			end else begin
				sel_q <= sel_q & ~(ack & ~req);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (grant[1]) begin
			rd_q <= ext_wb.rd;
			data_q <= ext_wb.data;
		end else if (grant[0]) begin
			rd_q <= adder_wb.rd;
			data_q <= adder_wb.data;
		end
	end

	assign rf_wb.req = strobe_q;
	assign rf_wb.rd = rd_q;
	assign rf_wb.data = data_q;

endmodule

// File: adder_subsys_top.sv
/*
 * adder issue subsystem.
 * issue buffer, issue select, adder, writeback arbiter and
 * physical register file, with plain dispatch and writeback ports.
 */
`timescale 1ns/100ps

module adder_subsys_top
	import adder_pkg::*;
(
	input logic CLK,
	input logic rst_n,
	input logic dispatch_req,
	input logic [OP_W-1:0] dispatch_op,
	input logic [XLEN-1:0] dispatch_pc,
	input logic [PHY_W-1:0] dispatch_rd,
	input logic [PHY_W-1:0] dispatch_rs1,
	input operand2_u dispatch_opnd2,
	output logic dispatch_ack,
	input logic alloc_valid,
	input logic [PHY_W-1:0] alloc_rd,
	input logic ext_wb_req,
	input logic [PHY_W-1:0] ext_wb_rd,
	input logic [XLEN-1:0] ext_wb_data,
	output logic ext_wb_ack,
	output logic wb_valid,
	output logic [PHY_W-1:0] wb_rd,
	output logic [XLEN-1:0] wb_data
);

	issue_buf_if issue_buf_bus ();
	rf_read_if rf_read_bus ();
	wb_if adder_wb_bus ();
	wb_if ext_wb_bus ();
	wb_if rf_wb_bus ();

	logic alloc_clr;
	logic [PHY_W-1:0] alloc_clr_rd;
	logic execute_valid;
	logic execute_ready;
	logic [OP_W-1:0] execute_op;
	logic [PHY_W-1:0] execute_rd;
	logic [XLEN-1:0] execute_op1;
	logic [XLEN-1:0] execute_op2;
	logic execute_is32;

	assign ext_wb_bus.req = ext_wb_req;
	assign ext_wb_bus.rd = ext_wb_rd;
	assign ext_wb_bus.data = ext_wb_data;
	assign ext_wb_ack = ext_wb_bus.ack;

	// monitor taps the register file write strobe.
	assign wb_valid = rf_wb_bus.req;
	assign wb_rd = rf_wb_bus.rd;
	assign wb_data = rf_wb_bus.data;

	adder_buffer buffer_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.dispatch_req(dispatch_req),
		.dispatch_op(dispatch_op),
		.dispatch_pc(dispatch_pc),
		.dispatch_rd(dispatch_rd),
		.dispatch_rs1(dispatch_rs1),
		.dispatch_opnd2(dispatch_opnd2),
		.dispatch_ack(dispatch_ack),
		.alloc_clr(alloc_clr),
		.alloc_clr_rd(alloc_clr_rd),
		.issue_buf(issue_buf_bus.src)
	);

	adder_issue issue_i (
		.execute_ready(execute_ready),
		.execute_valid(execute_valid),
		.execute_op(execute_op),
		.execute_rd(execute_rd),
		.execute_op1(execute_op1),
		.execute_op2(execute_op2),
		.execute_is32(execute_is32),
		.issue_buf(issue_buf_bus.sink),
		.rf(rf_read_bus.reader)
	);

	adder_execute execute_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.execute_valid(execute_valid),
		.execute_op(execute_op),
		.execute_rd(execute_rd),
		.execute_op1(execute_op1),
		.execute_op2(execute_op2),
		.execute_is32(execute_is32),
		.execute_ready(execute_ready),
		.wb(adder_wb_bus.requester)
	);

	wb_arbiter arbiter_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.adder_wb(adder_wb_bus.arbiter),
		.ext_wb(ext_wb_bus.arbiter),
		.rf_wb(rf_wb_bus.requester)
	);

	phy_regfile regfile_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.alloc_clr(alloc_clr),
		.alloc_clr_rd(alloc_clr_rd),
		.alloc_valid(alloc_valid),
		.alloc_rd(alloc_rd),
		.wr(rf_wb_bus.arbiter),
		.rd(rf_read_bus.port)
	);

endmodule

// File: tb_adder_subsys.sv
/*
 * random testbench for the adder issue subsystem.
 * plays renamer, dispatcher and external writer, and checks every
 * register write against a reference model of the add-class rules.
 */
`timescale 1ns/100ps

module tb_adder_subsys;
	import adder_pkg::*;

	localparam int N_OPS = 400;
	localparam int CYCLE_LIMIT = N_OPS * 40;
	localparam int N_RANDOM = N_OPS - ISSUE_DEPTH - 2;
	localparam int HOLD_CYCLES = 20;
	localparam int MAX_EXT_DELAY = 30;
	localparam logic [31:0] SEED = 32'habd3_573f;

	logic CLK;
	logic rst_n;
	logic dispatch_req;
	logic [OP_W-1:0] dispatch_op;
	logic [XLEN-1:0] dispatch_pc;
	logic [PHY_W-1:0] dispatch_rd;
	logic [PHY_W-1:0] dispatch_rs1;
	operand2_u dispatch_opnd2;
	logic dispatch_ack;
	logic alloc_valid;
	logic [PHY_W-1:0] alloc_rd;
	logic ext_wb_req;
	logic [PHY_W-1:0] ext_wb_rd;
	logic [XLEN-1:0] ext_wb_data;
	logic ext_wb_ack;
	logic wb_valid;
	logic [PHY_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;

	// reference model, indexed by physical tag.
	logic [XLEN-1:0] model_val [PHY_REGS];
	bit pending [PHY_REGS];
	bit by_ext [PHY_REGS];
	int readers [PHY_REGS];
	int kind_of [PHY_REGS];
	logic [XLEN-1:0] pc_of [PHY_REGS];
	logic [XLEN-1:0] imm_of [PHY_REGS];
	logic [PHY_W-1:0] rs1_of [PHY_REGS];
	logic [PHY_W-1:0] rs2_of [PHY_REGS];
	logic [XLEN-1:0] ext_data_of [PHY_REGS];
	logic [PHY_W-1:0] ext_queue [$];
	int ext_delay [$];
	int n_pending;
	int writes_seen;
	logic [PHY_W-1:0] last_rd;

	adder_subsys_top dut_i (
		.CLK(CLK),
		.rst_n(rst_n),
		.dispatch_req(dispatch_req),
		.dispatch_op(dispatch_op),
		.dispatch_pc(dispatch_pc),
		.dispatch_rd(dispatch_rd),
		.dispatch_rs1(dispatch_rs1),
		.dispatch_opnd2(dispatch_opnd2),
		.dispatch_ack(dispatch_ack),
		.alloc_valid(alloc_valid),
		.alloc_rd(alloc_rd),
		.ext_wb_req(ext_wb_req),
		.ext_wb_rd(ext_wb_rd),
		.ext_wb_data(ext_wb_data),
		.ext_wb_ack(ext_wb_ack),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail at time %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_tag(input logic [PHY_W-1:0] got);
		if (!pending[got]) begin
			stop_on_error($sformatf("Fail at time %0t: wb_rd got %0d expected a pending tag",
				$time, got));
		end
	endtask

	task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail at time %0t: wb_data got %h expected %h",
				$time, got, exp));
		end
	endtask

	function automatic bit needs_rs1(input int kind);
		return kind != OP_LUI && kind != OP_AUIPC;
	endfunction

	function automatic bit reg_form(input int kind);
		return kind == OP_ADD || kind == OP_ADDW || kind == OP_SUB || kind == OP_SUBW;
	endfunction

	function automatic logic [XLEN-1:0] expected_result(input int kind,
			input logic [XLEN-1:0] pc, input logic [XLEN-1:0] imm,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [XLEN-1:0] r;
		case (kind)
			OP_LUI: r = imm;
			OP_AUIPC: r = pc + imm;
			OP_ADDI, OP_ADDIW: r = a + imm;
			OP_ADD, OP_ADDW: r = a + b;
			default: r = a - b;
		endcase
		// word forms keep the low half and copy bit 31 upwards.
		if (kind == OP_ADDIW || kind == OP_ADDW || kind == OP_SUBW) begin
			r = {{(XLEN-32){r[31]}}, r[31:0]};
		end
		return r;
	endfunction

	// a tag is free when nothing will write it and nothing still reads it.
	task automatic pick_free_tag(output logic [PHY_W-1:0] tag);
		logic [PHY_W-1:0] free_tags [$];
		do begin
			free_tags.delete();
			for (int t = 0; t < PHY_REGS; t++) begin
				if (!pending[t] && readers[t] == 0) begin
					free_tags.push_back(PHY_W'(t));
				end
			end
			if (free_tags.size() == 0) begin
				@(negedge CLK);
			end
		end while (free_tags.size() == 0);
		tag = free_tags[$urandom_range(0, free_tags.size() - 1)];
	endtask

	function automatic logic [PHY_W-1:0] pick_source(input logic [PHY_W-1:0] rd);
		logic [PHY_W-1:0] tag;
		tag = ($urandom_range(0, 1) == 0) ? last_rd : PHY_W'($urandom);
		while (tag == rd) begin
			tag = PHY_W'($urandom);
		end
		return tag;
	endfunction

	task automatic drive_dispatch(input int kind, input logic [PHY_W-1:0] rd,
			input logic [PHY_W-1:0] rs1, input logic [PHY_W-1:0] rs2);
		logic [31:0] r;
		logic [XLEN-1:0] imm;
		r = $urandom;
		if (kind == OP_LUI || kind == OP_AUIPC) begin
			imm = {{32{r[31]}}, r[31:12], 12'h000};
		end else begin
			imm = {{52{r[11]}}, r[11:0]};
		end
		kind_of[rd] = kind;
		pc_of[rd] = {$urandom, $urandom} & ~64'h3;
		imm_of[rd] = imm;
		rs1_of[rd] = rs1;
		rs2_of[rd] = rs2;
		by_ext[rd] = 1'b0;
		pending[rd] = 1'b1;
		n_pending++;
		if (needs_rs1(kind)) begin
			readers[rs1]++;
		end
		if (reg_form(kind)) begin
			readers[rs2]++;
		end
		dispatch_op = OP_W'(1) << kind;
		dispatch_pc = pc_of[rd];
		dispatch_rd = rd;
		dispatch_rs1 = rs1;
		if (reg_form(kind)) begin
			dispatch_opnd2.reg_form.pad = '0;
			dispatch_opnd2.reg_form.rs2 = rs2;
		end else begin
			dispatch_opnd2.imm = imm;
		end
		dispatch_req = 1'b1;
	endtask

	task automatic finish_dispatch();
		do begin
			@(negedge CLK);
		end while (!dispatch_ack);
		dispatch_req = 1'b0;
		do begin
			@(negedge CLK);
		end while (dispatch_ack);
		last_rd = dispatch_rd;
	endtask

	task automatic random_dispatch();
		logic [PHY_W-1:0] rd;
		logic [PHY_W-1:0] rs1;
		logic [PHY_W-1:0] rs2;
		int kind;
		pick_free_tag(rd);
		kind = $urandom_range(0, OP_W - 1);
		rs1 = pick_source(rd);
		rs2 = pick_source(rd);
		drive_dispatch(kind, rd, rs1, rs2);
		finish_dispatch();
	endtask

	// claims a tag for the external writer; the write itself may be queued later.
	task automatic alloc_tag(input logic [PHY_W-1:0] tag, input bit queue_write);
		by_ext[tag] = 1'b1;
		pending[tag] = 1'b1;
		n_pending++;
		ext_data_of[tag] = {$urandom, $urandom};
		alloc_rd = tag;
		alloc_valid = 1'b1;
		@(negedge CLK);
		alloc_valid = 1'b0;
		if (queue_write) begin
			ext_queue.push_back(tag);
			ext_delay.push_back($urandom_range(0, MAX_EXT_DELAY));
		end
		last_rd = tag;
	endtask

	task automatic check_sources_written(input logic [PHY_W-1:0] tag);
		if (needs_rs1(kind_of[tag]) && pending[rs1_of[tag]]) begin
			stop_on_error($sformatf("tag %0d was written before its source tag %0d",
				tag, rs1_of[tag]));
		end
		if (reg_form(kind_of[tag]) && pending[rs2_of[tag]]) begin
			stop_on_error($sformatf("tag %0d was written before its source tag %0d",
				tag, rs2_of[tag]));
		end
	endtask

	task automatic retire(input logic [PHY_W-1:0] tag, input logic [XLEN-1:0] value);
		model_val[tag] = value;
		pending[tag] = 1'b0;
		n_pending--;
		writes_seen++;
		if (!by_ext[tag]) begin
			if (needs_rs1(kind_of[tag])) begin
				readers[rs1_of[tag]]--;
			end
			if (reg_form(kind_of[tag])) begin
				readers[rs2_of[tag]]--;
			end
		end
	endtask

	// the tag is released after the write edge so it cannot be reused in that cycle.
	initial begin : write_monitor
		logic [PHY_W-1:0] tag;
		logic [XLEN-1:0] exp;
		forever begin
			@(negedge CLK);
			if (rst_n && wb_valid) begin
				tag = wb_rd;
				check_tag(tag);
				if (by_ext[tag]) begin
					exp = ext_data_of[tag];
				end else begin
					check_sources_written(tag);
					exp = expected_result(kind_of[tag], pc_of[tag], imm_of[tag],
						model_val[rs1_of[tag]], model_val[rs2_of[tag]]);
				end
				check_data(wb_data, exp);
				@(posedge CLK);
				retire(tag, exp);
			end
		end
	end

	initial begin : ext_writer
		logic [PHY_W-1:0] tag;
		int delay;
		forever begin
			@(negedge CLK);
			if (ext_queue.size() != 0) begin
				tag = ext_queue.pop_front();
				delay = ext_delay.pop_front();
				repeat (delay) @(negedge CLK);
				ext_wb_rd = tag;
				ext_wb_data = ext_data_of[tag];
				ext_wb_req = 1'b1;
				do begin
					@(negedge CLK);
				end while (!ext_wb_ack);
				ext_wb_req = 1'b0;
				do begin
					@(negedge CLK);
				end while (ext_wb_ack);
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge CLK);
			cycles++;
			if (cycles >= CYCLE_LIMIT) begin
				stop_on_error($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
			end
		end
	end

	initial begin : stimulus
		logic [PHY_W-1:0] slow_tag;
		logic [PHY_W-1:0] rd;
		logic [PHY_W-1:0] rs2;
		int kind;
		void'($urandom(SEED));
		rst_n = 1'b0;
		dispatch_req = 1'b0;
		dispatch_op = '0;
		dispatch_pc = '0;
		dispatch_rd = '0;
		dispatch_rs1 = '0;
		dispatch_opnd2 = '0;
		alloc_valid = 1'b0;
		alloc_rd = '0;
		ext_wb_req = 1'b0;
		ext_wb_rd = '0;
		ext_wb_data = '0;
		n_pending = 0;
		writes_seen = 0;
		last_rd = '0;
		for (int t = 0; t < PHY_REGS; t++) begin
			model_val[t] = '0;
			pending[t] = 1'b0;
			by_ext[t] = 1'b0;
			readers[t] = 0;
		end
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
		check_flag(dispatch_ack, 1'b0, "dispatch_ack");
		check_flag(ext_wb_ack, 1'b0, "ext_wb_ack");
		check_flag(wb_valid, 1'b0, "wb_valid");

		for (int n = 0; n < N_RANDOM; n++) begin
			if ($urandom_range(0, 3) == 0) begin
				pick_free_tag(rd);
				alloc_tag(rd, 1'b1);
			end else begin
				random_dispatch();
			end
		end

		// fill the buffer behind one slow external source.
		while (n_pending != 0) begin
			@(negedge CLK);
		end
		pick_free_tag(slow_tag);
		alloc_tag(slow_tag, 1'b0);
		for (int i = 0; i <= ISSUE_DEPTH; i++) begin
			pick_free_tag(rd);
			kind = $urandom_range(OP_ADDI, OP_SUBW);
			rs2 = pick_source(rd);
			drive_dispatch(kind, rd, slow_tag, rs2);
			if (i == ISSUE_DEPTH) begin
				repeat (HOLD_CYCLES) begin
					@(negedge CLK);
					check_flag(dispatch_ack, 1'b0, "dispatch_ack");
				end
				ext_queue.push_back(slow_tag);
				ext_delay.push_back(0);
			end
			finish_dispatch();
		end

		while (n_pending != 0) begin
			@(negedge CLK);
		end
		repeat (20) @(negedge CLK);
		if (n_pending != 0 || writes_seen != N_OPS) begin
			stop_on_error($sformatf("run ended with %0d writes pending, %0d of %0d writes seen",
				n_pending, writes_seen, N_OPS));
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: build.f
adder_pkg.sv
adder_ifs.sv
adder_buffer.sv
adder_issue.sv
phy_regfile.sv
adder_execute.sv
wb_arbiter.sv
adder_subsys_top.sv
tb_adder_subsys.sv

// File: Bender.yml
package:
  name: adder_subsys

sources:
  - adder_pkg.sv
  - adder_ifs.sv
  - adder_buffer.sv
  - adder_issue.sv
  - phy_regfile.sv
  - adder_execute.sv
  - wb_arbiter.sv
  - adder_subsys_top.sv
  - target: simulation
    files:
      - tb_adder_subsys.sv
